// File: include/fence_join_defines.svh
/*
  Build-time sizes for the stream-join subsystem.
  The top level wires exactly two readers, so FJ_NB_LANES must stay 2 there.
  The fence and merge themselves work for any lane count.
*/
`ifndef FENCE_JOIN_DEFINES_SVH
`define FENCE_JOIN_DEFINES_SVH

// --------------------------------------------------
// lane geometry
// --------------------------------------------------

// number of narrow lanes joined into one wide word
`define FJ_NB_LANES 2

// bits per lane word, one whole Wishbone data word
`define FJ_LANE_WIDTH 32

// --------------------------------------------------
// bus and transfer sizes
// --------------------------------------------------

// Wishbone word address, not a byte address
`define FJ_ADDR_WIDTH 16

// word count per lane in one transfer
`define FJ_COUNT_WIDTH 8

`endif

// File: project.f
+incdir+include
verilog/stream_pkg.sv
verilog/wb_pkg.sv
verilog/wb_lane_reader.sv
verilog/stream_fence.sv
verilog/stream_merge.sv
verilog/fence_join_top.sv
testbench/tb_wb_mem_model.sv
testbench/tb_fence_join.sv

// File: testbench/tb_fence_join.sv
/*
  Testbench for the two-lane stream join with random ack delays and back-pressure.
  Inputs change on the falling edge; outputs are checked there too, while stable.
  Random bits come from a 16-bit Fibonacci LFSR, so every run is the same.
  The run stops at the first mismatch.
*/
`timescale 1ns/1ns

module tb_fence_join;

  import stream_pkg::*;
  import wb_pkg::*;

  localparam int         CLK_PERIOD = 40;
  localparam int         NB_ROWS    = 6;
  // worst ack latency of the memory model, in cycles
  localparam int         MAX_ACK    = 9;
  localparam logic [7:0] NO_CLEAR   = 8'hff;

  // one transfer with its bases, length, back-pressure flag and clear point
  typedef struct packed {
    wb_addr_t    base0;
    wb_addr_t    base1;
    word_count_t count;
    logic        bp;
    logic [7:0]  clear_at;
  } row_t;

  row_t        rows [NB_ROWS];
  logic [15:0] lfsr_q;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        clear;
  wb_addr_t    base0;
  wb_addr_t    base1;
  word_count_t count;
  logic        busy;
  logic        out_valid;
  logic        out_ready;
  wide_word_t  out_data;
  logic        out_last;
  logic [2:0]  delay0;
  logic [2:0]  delay1;
  logic        wb0_cyc;
  logic        wb0_stb;
  logic        wb0_we;
  logic        wb0_ack;
  logic        wb1_cyc;
  logic        wb1_stb;
  logic        wb1_we;
  logic        wb1_ack;
  wb_addr_t    wb0_adr;
  wb_addr_t    wb1_adr;
  wb_sel_t     wb0_sel;
  wb_sel_t     wb1_sel;
  lane_word_t  wb0_dat;
  lane_word_t  wb1_dat;

  fence_join_top i_dut (
    .clk_i (clk), .rst_ni (rst_n), .start_i (start), .clear_i (clear),
    .base0_i (base0), .base1_i (base1), .count_i (count), .busy_o (busy),
    .wb0_cyc_o (wb0_cyc), .wb0_stb_o (wb0_stb), .wb0_we_o (wb0_we),
    .wb0_adr_o (wb0_adr), .wb0_sel_o (wb0_sel), .wb0_dat_i (wb0_dat), .wb0_ack_i (wb0_ack),
    .wb1_cyc_o (wb1_cyc), .wb1_stb_o (wb1_stb), .wb1_we_o (wb1_we),
    .wb1_adr_o (wb1_adr), .wb1_sel_o (wb1_sel), .wb1_dat_i (wb1_dat), .wb1_ack_i (wb1_ack),
    .out_valid_o (out_valid), .out_ready_i (out_ready),
    .out_data_o (out_data), .out_last_o (out_last)
  );

  tb_wb_mem_model #(.LANE(0)) i_mem0 (
    .clk_i (clk), .rst_ni (rst_n), .cyc_i (wb0_cyc), .stb_i (wb0_stb),
    .adr_i (wb0_adr), .delay_i (delay0), .dat_o (wb0_dat), .ack_o (wb0_ack)
  );

  tb_wb_mem_model #(.LANE(1)) i_mem1 (
    .clk_i (clk), .rst_ni (rst_n), .cyc_i (wb1_cyc), .stb_i (wb1_stb),
    .adr_i (wb1_adr), .delay_i (delay1), .dat_o (wb1_dat), .ack_o (wb1_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // --------------------------------------------------
  // random source and expected values
  // --------------------------------------------------

  // taps x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at the bottom
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
  endtask

  // ack delays for both lanes, and out_ready at 3/4 when back-pressure is on
  task automatic drive_random(input logic bp);
    logic [7:0] v;
    draw_bits(3, v);
    delay0 = v[2:0];
    draw_bits(3, v);
    delay1 = v[2:0];
    if (bp)
    begin
      draw_bits(2, v);
      out_ready = |v[1:0];
    end
    else
      out_ready = 1'b1;
  endtask

  // lane id in the top byte and the address at the bottom
  function automatic lane_word_t lane_word(input int lane, input wb_addr_t a);
    return {8'(lane), 8'h00, a};
  endfunction

  // lane 0 in the low half
  function automatic wide_word_t expected_wide(input row_t r, input int k);
    return {lane_word(1, wb_addr_t'(r.base1 + k)), lane_word(0, wb_addr_t'(r.base0 + k))};
  endfunction

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_wide(input string name, input wide_word_t got, input wide_word_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sel(input string name, input wb_sel_t got, input wb_sel_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // nothing running, nothing on the bus, nothing on the output
  task automatic check_idle();
    check_bit("out_valid_o", out_valid, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("wb0_cyc_o", wb0_cyc, 1'b0);
    check_bit("wb1_cyc_o", wb1_cyc, 1'b0);
  endtask

  // reads only, and every byte of the word selected
  task automatic check_bus_reads();
    check_bit("wb0_we_o", wb0_we, 1'b0);
    check_bit("wb1_we_o", wb1_we, 1'b0);
    check_sel("wb0_sel_o", wb0_sel, 4'hf);
    check_sel("wb1_sel_o", wb1_sel, 4'hf);
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  task automatic load_table();
    rows[0] = '{16'h0000, 16'h0100, 8'd4,  1'b0, NO_CLEAR};
    rows[1] = '{16'h0200, 16'h0303, 8'd9,  1'b0, NO_CLEAR};
    rows[2] = '{16'h1000, 16'h2000, 8'd12, 1'b1, NO_CLEAR};
    // aborted after three words, then the next row must run cleanly
    rows[3] = '{16'h0040, 16'h0a00, 8'd10, 1'b1, 8'd3};
    rows[4] = '{16'h0050, 16'h0b00, 8'd6,  1'b1, NO_CLEAR};
    // lane 0 wraps past the top of the address space
    rows[5] = '{16'hfffd, 16'h7ffe, 8'd5,  1'b0, NO_CLEAR};
  endtask

  task automatic run_row(input row_t r);
    int         got;
    logic       stalled;
    wide_word_t held_data;
    logic       held_last;
    got       = 0;
    stalled   = 1'b0;
    held_data = '0;
    held_last = 1'b0;
    @(negedge clk);
    drive_random(r.bp);
    base0 = r.base0;
    base1 = r.base1;
    count = r.count;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (got < int'(r.count))
    begin
      drive_random(r.bp);
      // busy from the start edge until the last word is taken
      check_bit("busy_o", busy, 1'b1);
      check_bus_reads();
      // word refused at the last edge must still be there unchanged
      if (stalled)
      begin
        check_bit("out_valid_o", out_valid, 1'b1);
        check_wide("out_data_o", out_data, held_data);
        check_bit("out_last_o", out_last, held_last);
      end
      if (got == int'(r.clear_at))
      begin
        out_ready = 1'b0;
        clear     = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        check_idle();
        return;
      end
      // accepted at the coming edge
      if (out_valid && out_ready)
      begin
        check_wide("out_data_o", out_data, expected_wide(r, got));
        check_bit("out_last_o", out_last, got == int'(r.count) - 1);
        got++;
      end
      stalled   = out_valid && !out_ready;
      held_data = out_data;
      held_last = out_last;
      @(negedge clk);
    end
    // no extra word may follow the last one
    repeat (3)
    begin
      check_idle();
      @(negedge clk);
    end
  endtask

  initial
  begin
    load_table();
    lfsr_q     = 16'd91;
    rst_n      = 1'b0;
    start      = 1'b0;
    clear      = 1'b0;
    base0      = '0;
    base1      = '0;
    count      = '0;
    out_ready  = 1'b0;
    delay0     = '0;
    delay1     = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    // quiet until the first start
    repeat (4)
    begin
      @(negedge clk);
      check_idle();
    end
    for (int i = 0; i < NB_ROWS; i++)
      run_row(rows[i]);
    $display("Everything OK");
    $finish;
  end

  // bound from the total word count and the worst ack latency
  initial
  begin
    int total;
    #1;
    total = 0;
    for (int i = 0; i < NB_ROWS; i++)
      total += int'(rows[i].count);
    #((total * (MAX_ACK + 4) + 500) * CLK_PERIOD);
    $display("timeout: the transfers did not finish in the expected time");
    abort_run();
  end

endmodule

// File: testbench/tb_wb_mem_model.sv
/*
  Wishbone classic slave memory for one lane of the testbench, reads only.
  The word at address a is {LANE, 8'h00, a}, so there is no storage array.
  Each request waits delay_i more cycles, sampled when the request is first seen.
  The ack comes 2 to 9 cycles after cyc rises.
*/
`timescale 1ns/1ns

module tb_wb_mem_model #(
  parameter int LANE = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  wb_pkg::wb_addr_t       adr_i,
  input  logic [2:0]             delay_i,
  output stream_pkg::lane_word_t dat_o,
  output logic                   ack_o
);

  import wb_pkg::*;
  import stream_pkg::*;

  logic       pend_q;
  logic [2:0] wait_q;

  // content follows from lane and address alone
  function automatic lane_word_t word_at(input wb_addr_t a);
    return {8'(LANE), 8'h00, a};
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o  <= 1'b0;
      pend_q <= 1'b0;
      wait_q <= '0;
      dat_o  <= '0;
    end
    else if (ack_o || !(cyc_i && stb_i))
    begin
      // ack lasts one cycle, and a dropped cycle forgets its request
      ack_o  <= 1'b0;
      pend_q <= 1'b0;
    end
    else if (!pend_q)
    begin
      // pick the wait time of a new request
      pend_q <= 1'b1;
      wait_q <= delay_i;
    end
    else if (wait_q == '0)
    begin
      ack_o <= 1'b1;
      dat_o <= word_at(adr_i);
    end
    else
      wait_q <= wait_q - 1'b1;
  end

endmodule

// File: verilog/fence_join_top.sv
/*
  Two Wishbone lane readers joined into one 64-bit stream.
  start_i is taken only while busy_o is low; clear_i aborts everything.
  Both lanes read count_i words, each from its own base address.
*/
`timescale 1ns/1ns
`include "fence_join_defines.svh"

module fence_join_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic                    clear_i,
  input  wb_pkg::wb_addr_t        base0_i,
  input  wb_pkg::wb_addr_t        base1_i,
  input  stream_pkg::word_count_t count_i,
  output logic                    busy_o,
  // lane 0 memory port
  output logic                    wb0_cyc_o,
  output logic                    wb0_stb_o,
  output logic                    wb0_we_o,
  output wb_pkg::wb_addr_t        wb0_adr_o,
  output wb_pkg::wb_sel_t         wb0_sel_o,
  input  stream_pkg::lane_word_t  wb0_dat_i,
  input  logic                    wb0_ack_i,
  // lane 1 memory port
  output logic                    wb1_cyc_o,
  output logic                    wb1_stb_o,
  output logic                    wb1_we_o,
  output wb_pkg::wb_addr_t        wb1_adr_o,
  output wb_pkg::wb_sel_t         wb1_sel_o,
  input  stream_pkg::lane_word_t  wb1_dat_i,
  input  logic                    wb1_ack_i,
  // joined output stream
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output stream_pkg::wide_word_t  out_data_o,
  output logic                    out_last_o
);

  import stream_pkg::*;

  logic       start_ok;
  logic       merge_done;
  logic       lane_valid  [`FJ_NB_LANES];
  logic       lane_ready  [`FJ_NB_LANES];
  lane_word_t lane_data   [`FJ_NB_LANES];
  logic       lane_last   [`FJ_NB_LANES];
  logic       reader_busy [`FJ_NB_LANES];
  logic       fenced_valid;
  logic       fenced_ready;
  lane_word_t fenced_data [`FJ_NB_LANES];
  logic       fenced_last [`FJ_NB_LANES];

  // no restart while any word is still on its way out
  assign start_ok = start_i && !busy_o;
  assign busy_o   = reader_busy[0] || reader_busy[1] || out_valid_o;

  // --------------------------------------------------
  // lane readers
  // --------------------------------------------------

  wb_lane_reader i_reader0 (
    .clk_i, .rst_ni, .clear_i,
    .start_i  (start_ok),
    .base_i   (base0_i),
    .count_i,
    .wb_cyc_o (wb0_cyc_o),
    .wb_stb_o (wb0_stb_o),
    .wb_we_o  (wb0_we_o),
    .wb_adr_o (wb0_adr_o),
    .wb_sel_o (wb0_sel_o),
    .wb_dat_i (wb0_dat_i),
    .wb_ack_i (wb0_ack_i),
    .valid_o  (lane_valid[0]),
    .ready_i  (lane_ready[0]),
    .data_o   (lane_data[0]),
    .last_o   (lane_last[0]),
    .busy_o   (reader_busy[0])
  );

  wb_lane_reader i_reader1 (
    .clk_i, .rst_ni, .clear_i,
    .start_i  (start_ok),
    .base_i   (base1_i),
    .count_i,
    .wb_cyc_o (wb1_cyc_o),
    .wb_stb_o (wb1_stb_o),
    .wb_we_o  (wb1_we_o),
    .wb_adr_o (wb1_adr_o),
    .wb_sel_o (wb1_sel_o),
    .wb_dat_i (wb1_dat_i),
    .wb_ack_i (wb1_ack_i),
    .valid_o  (lane_valid[1]),
    .ready_i  (lane_ready[1]),
    .data_o   (lane_data[1]),
    .last_o   (lane_last[1]),
    .busy_o   (reader_busy[1])
  );

  // --------------------------------------------------
  // fence and merge
  // --------------------------------------------------

  stream_fence i_fence (
    .clk_i, .rst_ni, .clear_i,
    .in_valid_i  (lane_valid),
    .in_data_i   (lane_data),
    .in_last_i   (lane_last),
    .out_ready_i (fenced_ready),
    .in_ready_o  (lane_ready),
    .out_valid_o (fenced_valid),
    .out_data_o  (fenced_data),
    .out_last_o  (fenced_last)
  );

  stream_merge i_merge (
    .clk_i, .rst_ni, .clear_i,
    .in_valid_i  (fenced_valid),
    .in_data_i   (fenced_data),
    .in_last_i   (fenced_last),
    .out_ready_i,
    .in_ready_o  (fenced_ready),
    .out_valid_o,
    .out_data_o,
    .out_last_o,
    .done_o      (merge_done)
  );

  // readers and fence must be drained by the time the last wide word leaves
  a_idle_after_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    merge_done |=> !busy_o)
    else $error("busy still high after the last word");

endmodule

// File: verilog/stream_fence.sv
/*
  Fence that lets all lanes leave together, with no added latency.
  An early lane word is parked in a register until the other lanes catch up.
  Sources must hold valid and data while waiting, as on any lane stream.
*/
`timescale 1ns/1ns
`include "fence_join_defines.svh"

module stream_fence (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   in_valid_i  [`FJ_NB_LANES],
  input  stream_pkg::lane_word_t in_data_i   [`FJ_NB_LANES],
  input  logic                   in_last_i   [`FJ_NB_LANES],
  input  logic                   out_ready_i,
  output logic                   in_ready_o  [`FJ_NB_LANES],
  output logic                   out_valid_o,
  output stream_pkg::lane_word_t out_data_o  [`FJ_NB_LANES],
  output logic                   out_last_o  [`FJ_NB_LANES]
);

  import stream_pkg::*;

  logic [`FJ_NB_LANES-1:0] in_valid;
  logic [`FJ_NB_LANES-1:0] hold_q;
  logic [`FJ_NB_LANES-1:0] hold_set;
  logic                    fire;
  lane_word_t              data_q [`FJ_NB_LANES];
  logic                    last_q [`FJ_NB_LANES];

  // --------------------------------------------------
  // fence condition
  // --------------------------------------------------

  // every lane is either live now or already parked
  assign out_valid_o = &(in_valid | hold_q);
  assign fire        = out_valid_o && out_ready_i;

  for (genvar lane = 0; lane < `FJ_NB_LANES; lane++)
  begin : gen_lane
    assign in_valid[lane] = in_valid_i[lane];

    // early arrival, taken in while the fence is still open
    assign hold_set[lane] = in_valid[lane] && !hold_q[lane] && !out_valid_o;

    // parked lanes take nothing more
    // live lanes follow the downstream ready once the fence is complete
    assign in_ready_o[lane] = !hold_q[lane] && (out_ready_i || !out_valid_o);

    assign out_data_o[lane] = hold_q[lane] ? data_q[lane] : in_data_i[lane];
    assign out_last_o[lane] = hold_q[lane] ? last_q[lane] : in_last_i[lane];

    always_ff @(posedge clk_i)
    begin
      if (hold_set[lane])
      begin
        data_q[lane] <= in_data_i[lane];
        last_q[lane] <= in_last_i[lane];
      end
    end

    // parked word must reach the output unchanged
    a_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hold_q[lane] |=> $stable(data_q[lane]) && $stable(last_q[lane]))
      else $error("held lane %0d register changed", lane);
  end

  // --------------------------------------------------
  // hold bits
  // --------------------------------------------------

  // cleared only by a fenced transfer, so a stalled fence keeps its words
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      hold_q <= '0;
    else if (clear_i)
      hold_q <= '0;
    else if (fire)
      hold_q <= '0;
    else
      hold_q <= hold_q | hold_set;
  end

endmodule

// File: verilog/stream_merge.sv
/*
  One-entry register stage joining the fenced lanes into one wide word.
  Lane 0 goes to the low bits; last is taken from lane 0.
  Runs at full rate when downstream is always ready.
*/
`timescale 1ns/1ns
`include "fence_join_defines.svh"

module stream_merge (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   in_valid_i,
  input  stream_pkg::lane_word_t in_data_i [`FJ_NB_LANES],
  input  logic                   in_last_i [`FJ_NB_LANES],
  input  logic                   out_ready_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output stream_pkg::wide_word_t out_data_o,
  output logic                   out_last_o,
  output logic                   done_o
);

  import stream_pkg::*;

  logic                    accept;
  logic                    valid_q;
  logic                    last_q;
  wide_word_t              joined;
  wide_word_t              data_q;
  logic [`FJ_NB_LANES-1:0] last_vec;

  // lane n into slice n of the wide word
  always_comb
  begin
    for (int lane = 0; lane < `FJ_NB_LANES; lane++)
    begin
      joined[lane*`FJ_LANE_WIDTH +: `FJ_LANE_WIDTH] = in_data_i[lane];
      last_vec[lane] = in_last_i[lane];
    end
  end

  // --------------------------------------------------
  // register stage
  // --------------------------------------------------

  // empty, or the held word leaves at this edge
  assign in_ready_o = !valid_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= 1'b0;
    else if (clear_i)
      valid_q <= 1'b0;
    else if (accept)
      valid_q <= 1'b1;
    else if (out_ready_i)
      valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      data_q <= joined;
      last_q <= in_last_i[0];
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;
  assign out_last_o  = last_q;

  // one-cycle pulse as the final wide word goes out
  assign done_o = valid_q && out_ready_i && last_q;

  // lanes come from separate readers and must finish on the same word
  a_last_agree: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (&last_vec) || !(|last_vec))
    else $error("lane last flags disagree");

endmodule

// File: verilog/stream_pkg.sv
/*
  Types on the stream side of the join.
  The wide word puts lane 0 in the least significant bits.
  A word count of zero starts no transfer.
*/
`include "fence_join_defines.svh"

package stream_pkg;

  // --------------------------------------------------
  // lane and joined words
  // --------------------------------------------------

  // one lane's data word, as fetched from its memory port
  typedef logic [`FJ_LANE_WIDTH-1:0] lane_word_t;

  // all lanes side by side
  // lane n sits at bits n*FJ_LANE_WIDTH and up
  typedef logic [`FJ_NB_LANES*`FJ_LANE_WIDTH-1:0] wide_word_t;

  // --------------------------------------------------
  // transfer length
  // --------------------------------------------------

  // words per lane, the same count for every lane
  typedef logic [`FJ_COUNT_WIDTH-1:0] word_count_t;

endpackage

// File: verilog/wb_lane_reader.sv
/*
  Wishbone classic read master for one lane, reads only, no bursts.
  One request is outstanding at a time and one word is buffered.
  start_i is ignored while busy_o is high; clear_i drops an open bus cycle.
  A count of zero leaves the reader idle.
*/
`timescale 1ns/1ns

module wb_lane_reader (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  wb_pkg::wb_addr_t        base_i,
  input  stream_pkg::word_count_t count_i,
  // Wishbone classic master
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output wb_pkg::wb_addr_t        wb_adr_o,
  output wb_pkg::wb_sel_t         wb_sel_o,
  input  stream_pkg::lane_word_t  wb_dat_i,
  input  logic                    wb_ack_i,
  // lane stream towards the fence
  output logic                    valid_o,
  input  logic                    ready_i,
  output stream_pkg::lane_word_t  data_o,
  output logic                    last_o,
  output logic                    busy_o
);

  import wb_pkg::*;
  import stream_pkg::*;

  wb_addr_t    adr_q;
  word_count_t remain_q;
  logic        cyc_q;
  logic        slot_valid_q;
  lane_word_t  slot_data_q;
  logic        slot_last_q;
  logic        start_ok;
  logic        ack;
  logic        slot_free;
  logic        issue;

  // --------------------------------------------------
  // request control
  // --------------------------------------------------

  assign start_ok = start_i && !busy_o;

  // ack only counts inside our own cycle
  assign ack = cyc_q && wb_ack_i;

  // slot is empty now or drains at this edge
  assign slot_free = !slot_valid_q || ready_i;

  // next read once the previous one is done and there is room for its word
  assign issue = !cyc_q && (remain_q != '0) && slot_free;

  // remain_q counts words not yet acknowledged
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cyc_q    <= 1'b0;
      remain_q <= '0;
      adr_q    <= '0;
    end
    else if (clear_i)
    begin
      cyc_q    <= 1'b0;
      remain_q <= '0;
    end
    else if (start_ok)
    begin
      // first request goes out right away
      cyc_q    <= (count_i != '0);
      remain_q <= count_i;
      adr_q    <= base_i;
    end
    else if (ack)
    begin
      // classic cycle ends with the ack
      cyc_q    <= 1'b0;
      remain_q <= remain_q - 1'b1;
      adr_q    <= adr_q + 1'b1;
    end
    else if (issue)
    begin
      cyc_q <= 1'b1;
    end
  end

  // --------------------------------------------------
  // one-word slot
  // --------------------------------------------------

  // an ack never meets a full slot, issue waits for room
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      slot_valid_q <= 1'b0;
    else if (clear_i)
      slot_valid_q <= 1'b0;
    else if (ack)
      slot_valid_q <= 1'b1;
    else if (ready_i)
      slot_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (ack)
    begin
      slot_data_q <= wb_dat_i;
      // final word when this ack takes the last outstanding one
      slot_last_q <= (remain_q == word_count_t'(1));
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;
  assign wb_sel_o = '1;

  assign valid_o = slot_valid_q;
  assign data_o  = slot_data_q;
  assign last_o  = slot_last_q;

  // busy until the last word has left the slot
  assign busy_o = (remain_q != '0) || slot_valid_q;

  // strobe outside a bus cycle is a protocol error
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> wb_cyc_o)
    else $error("stb high without cyc");

  // slave may sample the address in any cycle up to its ack
  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o))
    else $error("adr changed while waiting for ack");

endmodule

// File: verilog/wb_pkg.sv
/*
  Types on the Wishbone side of the join.
  Addresses count words, and every access is a whole word.
*/
`include "fence_join_defines.svh"

package wb_pkg;

  // word address, incremented by one per data word
  typedef logic [`FJ_ADDR_WIDTH-1:0] wb_addr_t;

  // one select bit per byte of a lane word
  // driven all ones, no partial accesses
  typedef logic [`FJ_LANE_WIDTH/8-1:0] wb_sel_t;

endpackage
